// ==== rtl/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // base opcodes of the supported subset
  localparam logic [6:0] op_rtype     = 7'b0110011;
  localparam logic [6:0] op_itype_alu = 7'b0010011;
  localparam logic [6:0] op_load      = 7'b0000011;
  localparam logic [6:0] op_store     = 7'b0100011;
  localparam logic [6:0] op_branch    = 7'b1100011;
  localparam logic [6:0] op_lui       = 7'b0110111;
  localparam logic [6:0] op_jal       = 7'b1101111;

  // writeback source
  localparam logic [1:0] res_alu  = 2'b00;
  localparam logic [1:0] res_load = 2'b01;
  localparam logic [1:0] res_imm  = 2'b10;
  localparam logic [1:0] res_pc4  = 2'b11;

  // next pc select, resolved in E
  localparam logic [1:0] pc_plus4  = 2'b00;
  localparam logic [1:0] pc_branch = 2'b01;
  localparam logic [1:0] pc_jump   = 2'b10;

  // E-stage operand source
  localparam logic [1:0] fwd_reg      = 2'b00;
  localparam logic [1:0] fwd_w_result = 2'b01;
  localparam logic [1:0] fwd_m_imm    = 2'b10;
  localparam logic [1:0] fwd_m_alu    = 2'b11;

  localparam logic [2:0] alu_add = 3'd0;
  localparam logic [2:0] alu_sub = 3'd1;
  localparam logic [2:0] alu_and = 3'd2;
  localparam logic [2:0] alu_or  = 3'd3;
  localparam logic [2:0] alu_xor = 3'd4;
  localparam logic [2:0] alu_slt = 3'd5;

  // one instruction word, seen through each encoding format
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } r_fmt;
    struct packed {
      logic [11:0]           imm;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } i_fmt;
    struct packed {
      logic [6:0]            imm_hi;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [4:0]            imm_lo;
      logic [6:0]            opcode;
    } s_fmt;
    struct packed {
      logic                  imm_12;
      logic [5:0]            imm_10_5;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [3:0]            imm_4_1;
      logic                  imm_11;
      logic [6:0]            opcode;
    } b_fmt;
    struct packed {
      logic [19:0]           imm;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } u_fmt;
    struct packed {
      logic                  imm_20;
      logic [9:0]            imm_10_1;
      logic                  imm_11;
      logic [7:0]            imm_19_12;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } j_fmt;
  } instr_t;

endpackage

// ==== rtl/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic [2:0]  ctl,
  output logic [31:0] y,
  output logic        zero
);
  import rv_pkg::*;

  always_comb begin
    case (ctl)
      alu_sub: y = a - b;
      alu_and: y = a & b;
      alu_or:  y = a | b;
      alu_xor: y = a ^ b;
      alu_slt: y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      default: y = a + b; // alu_add
    endcase
  end

  assign zero = (y == '0); // beq/bne decision

endmodule

// ==== rtl/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic        clk,
  input  logic        reset_x,
  input  logic [4:0]  ra1,
  input  logic [4:0]  ra2,
  input  logic [4:0]  wa,
  input  logic        we,
  input  logic [31:0] wd,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);
  logic [31:0] regs [32];

  // architectural state starts at zero
  always_ff @(posedge clk or negedge reset_x) begin
    if (!reset_x) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (we && wa != 5'd0) begin
      regs[wa] <= wd;
    end
  end

  // W writes in the same cycle D reads
  assign rd1 = (ra1 == 5'd0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

// ==== rtl/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
  input  rv_pkg::instr_t instr,
  output logic           reg_write,
  output logic [1:0]     result_src,
  output logic           mem_write,
  output logic [2:0]     alu_ctl,
  output logic           alu_src,
  output logic           branch,
  output logic           branch_ne,
  output logic           jump,
  output logic [31:0]    imm
);
  import rv_pkg::*;

  always_comb begin
    // defaults give a bubble
    reg_write  = 1'b0;
    result_src = res_alu;
    mem_write  = 1'b0;
    alu_ctl    = alu_add;
    alu_src    = 1'b0;
    branch     = 1'b0;
    branch_ne  = 1'b0;
    jump       = 1'b0;
    imm        = '0;

    case (instr.r_fmt.opcode)
      op_rtype: begin
        reg_write = 1'b1;
        case (instr.r_fmt.funct3)
          3'b000:  alu_ctl = instr.r_fmt.funct7[5] ? alu_sub : alu_add;
          3'b010:  alu_ctl = alu_slt;
          3'b100:  alu_ctl = alu_xor;
          3'b110:  alu_ctl = alu_or;
          3'b111:  alu_ctl = alu_and;
          default: alu_ctl = alu_add;
        endcase
      end
      op_itype_alu: begin // addi only
        reg_write = 1'b1;
        alu_src   = 1'b1;
        imm       = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
      end
      op_load: begin
        reg_write  = 1'b1;
        result_src = res_load;
        alu_src    = 1'b1; // base + offset
        imm        = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
      end
      op_store: begin
        mem_write = 1'b1;
        alu_src   = 1'b1;
        imm       = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
      end
      op_branch: begin
        branch    = 1'b1;
        alu_ctl   = alu_sub; // compare through the zero flag
        branch_ne = instr.b_fmt.funct3[0];
        imm       = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                     instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
      end
      op_lui: begin
        reg_write  = 1'b1;
        result_src = res_imm;
        imm        = {instr.u_fmt.imm, 12'b0};
      end
      op_jal: begin
        reg_write  = 1'b1;
        result_src = res_pc4; // link value
        jump       = 1'b1;
        imm        = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                      instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
      end
      default: ;
    endcase
  end

endmodule

// ==== rtl/hazard.sv ====
`timescale 1ns/1ps

module hazard (
  input  logic       clk,
  input  logic       reset_x,
  input  logic [4:0] d_rs1,
  input  logic [4:0] d_rs2,
  input  logic [4:0] e_rs1,
  input  logic [4:0] e_rs2,
  input  logic [4:0] e_rd,
  input  logic [4:0] m_rd,
  input  logic [4:0] w_rd,
  input  logic [1:0] e_result_src,
  input  logic [1:0] m_result_src,
  input  logic       m_reg_write,
  input  logic       w_reg_write,
  input  logic [1:0] e_pc_src,
  output logic [1:0] fwd_a,
  output logic [1:0] fwd_b,
  output logic       f_stall,
  output logic       d_stall,
  output logic       d_flush,
  output logic       e_flush
);
  import rv_pkg::*;

  logic load_use;
  logic stall;
  logic stall_q; // bubble already inserted last cycle

  // the nearest producer wins, x0 never forwards
  function automatic logic [1:0] fwd_sel(input logic [reg_addr_w-1:0] src);
    logic m_hit;
    logic [1:0] sel;
    m_hit = m_reg_write && (src == m_rd);
    sel   = fwd_reg;
    if (src != '0) begin
      if (m_hit && m_result_src == res_alu)
        sel = fwd_m_alu;
      else if (m_hit && m_result_src == res_imm)
        sel = fwd_m_imm; // lui
      else if (w_reg_write && src == w_rd)
        sel = fwd_w_result;
    end
    return sel;
  endfunction

  always_comb begin
    fwd_a = fwd_sel(e_rs1);
    fwd_b = fwd_sel(e_rs2);
  end

  assign load_use = (e_result_src == res_load) && (e_rd != '0)
                    && ((e_rd == d_rs1) || (e_rd == d_rs2));
  assign stall    = load_use && !stall_q;

  always_ff @(posedge clk or negedge reset_x) begin
    if (!reset_x)
      stall_q <= 1'b0;
    else
      stall_q <= stall;
  end

  assign f_stall = stall;
  assign d_stall = stall;
  assign d_flush = (e_pc_src != pc_plus4);  // redirect drops D
  assign e_flush = d_flush || stall;        // and E, or a load-use bubble

endmodule

// ==== rtl/rv_datapath.sv ====
`timescale 1ns/1ps

module rv_datapath (
  input  logic           clk,
  input  logic           reset_x,
  input  logic [31:0]    imem_rdata,
  input  logic [31:0]    dmem_rdata,
  // D-stage control from the decoder
  input  logic           reg_write,
  input  logic [1:0]     result_src,
  input  logic           mem_write,
  input  logic [2:0]     alu_ctl,
  input  logic           alu_src,
  input  logic           branch,
  input  logic           branch_ne,
  input  logic           jump,
  input  logic [31:0]    imm,
  // from the hazard unit
  input  logic [1:0]     fwd_a,
  input  logic [1:0]     fwd_b,
  input  logic           f_stall,
  input  logic           d_stall,
  input  logic           d_flush,
  input  logic           e_flush,
  output rv_pkg::instr_t d_instr,
  // to the hazard unit
  output logic [4:0]     d_rs1,
  output logic [4:0]     d_rs2,
  output logic [4:0]     e_rs1,
  output logic [4:0]     e_rs2,
  output logic [4:0]     e_rd,
  output logic [4:0]     m_rd,
  output logic [4:0]     w_rd,
  output logic [1:0]     e_result_src,
  output logic [1:0]     m_result_src,
  output logic           m_reg_write,
  output logic           w_reg_write,
  output logic [1:0]     e_pc_src,
  // memories and retire trace
  output logic [31:0]    imem_addr,
  output logic [31:0]    dmem_addr,
  output logic [31:0]    dmem_wdata,
  output logic           dmem_we,
  output logic           retire_valid,
  output logic [31:0]    retire_pc,
  output logic [4:0]     retire_rd,
  output logic [31:0]    retire_data
);
  import rv_pkg::*;

  logic [xlen-1:0] f_pc;
  logic [xlen-1:0] f_pc_next;
  logic            d_valid;
  logic            d_live;
  logic [xlen-1:0] d_pc;
  logic [xlen-1:0] d_rd1;
  logic [xlen-1:0] d_rd2;
  logic            e_valid;
  logic            e_reg_write;
  logic            e_mem_write;
  logic [2:0]      e_alu_ctl;
  logic            e_alu_src;
  logic            e_branch;
  logic            e_branch_ne;
  logic            e_jump;
  logic [xlen-1:0] e_pc;
  logic [xlen-1:0] e_rd1;
  logic [xlen-1:0] e_rd2;
  logic [xlen-1:0] e_imm;
  logic [xlen-1:0] e_src_a;
  logic [xlen-1:0] e_fwd_b;
  logic [xlen-1:0] e_alu_y;
  logic            e_zero;
  logic            e_taken;
  logic [xlen-1:0] e_target;
  logic            m_valid;
  logic            m_mem_write;
  logic [xlen-1:0] m_alu_y;
  logic [xlen-1:0] m_wdata;
  logic [xlen-1:0] m_imm;
  logic [xlen-1:0] m_pc;
  logic            w_valid;
  logic [1:0]      w_result_src;
  logic [xlen-1:0] w_alu_y;
  logic [xlen-1:0] w_load;
  logic [xlen-1:0] w_imm;
  logic [xlen-1:0] w_pc;
  logic [xlen-1:0] w_result;

  // fetch
  assign imem_addr = f_pc;
  assign f_pc_next = (e_pc_src != pc_plus4) ? e_target :
                     f_stall                ? f_pc     : f_pc + 32'd4;

  always_ff @(posedge clk or negedge reset_x) begin
    if (!reset_x)
      f_pc <= '0;
    else
      f_pc <= f_pc_next;
  end

  // F/D
  always_ff @(posedge clk or negedge reset_x) begin
    if (!reset_x)
      d_valid <= 1'b0;
    else if (d_flush)
      d_valid <= 1'b0;
    else if (!d_stall)
      d_valid <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!d_stall) begin
      d_instr <= imem_rdata;
      d_pc    <= f_pc;
    end
  end

  // decode
  assign d_rs1  = d_valid ? d_instr.r_fmt.rs1 : '0;
  assign d_rs2  = d_valid ? d_instr.r_fmt.rs2 : '0;
  assign d_live = d_valid && !e_flush; // otherwise a bubble enters E

  rv_regfile rf0 (
    .clk     (clk),
    .reset_x (reset_x),
    .ra1     (d_instr.r_fmt.rs1),
    .ra2     (d_instr.r_fmt.rs2),
    .wa      (w_rd),
    .we      (w_reg_write),
    .wd      (w_result),
    .rd1     (d_rd1),
    .rd2     (d_rd2)
  );

  // D/E
  always_ff @(posedge clk or negedge reset_x) begin
    if (!reset_x) begin
      e_valid      <= 1'b0;
      e_reg_write  <= 1'b0;
      e_result_src <= res_alu;
      e_mem_write  <= 1'b0;
      e_branch     <= 1'b0;
      e_jump       <= 1'b0;
    end else begin
      e_valid      <= d_live;
      e_reg_write  <= d_live && reg_write;
      e_result_src <= d_live ? result_src : res_alu;
      e_mem_write  <= d_live && mem_write;
      e_branch     <= d_live && branch;
      e_jump       <= d_live && jump;
    end
  end

  always_ff @(posedge clk) begin
    e_alu_ctl   <= alu_ctl;
    e_alu_src   <= alu_src;
    e_branch_ne <= branch_ne;
    e_pc        <= d_pc;
    e_rd1       <= d_rd1;
    e_rd2       <= d_rd2;
    e_imm       <= imm;
    e_rs1       <= d_instr.r_fmt.rs1;
    e_rs2       <= d_instr.r_fmt.rs2;
    e_rd        <= d_instr.r_fmt.rd;
  end

  // execute
  function automatic logic [xlen-1:0] fwd_pick(input logic [1:0] sel,
                                               input logic [xlen-1:0] reg_val);
    case (sel)
      fwd_w_result: return w_result;
      fwd_m_imm:    return m_imm;
      fwd_m_alu:    return m_alu_y;
      default:      return reg_val;
    endcase
  endfunction

  always_comb begin
    e_src_a = fwd_pick(fwd_a, e_rd1);
    e_fwd_b = fwd_pick(fwd_b, e_rd2); // also the store data
  end

  rv_alu alu0 (
    .a    (e_src_a),
    .b    (e_alu_src ? e_imm : e_fwd_b),
    .ctl  (e_alu_ctl),
    .y    (e_alu_y),
    .zero (e_zero)
  );

  assign e_taken  = e_branch && (e_zero ^ e_branch_ne);
  assign e_target = e_pc + e_imm; // branches and jal are both pc relative

  always_comb begin
    if (e_jump)
      e_pc_src = pc_jump;
    else if (e_taken)
      e_pc_src = pc_branch;
    else
      e_pc_src = pc_plus4;
  end

  // E/M
  always_ff @(posedge clk or negedge reset_x) begin
    if (!reset_x) begin
      m_valid      <= 1'b0;
      m_reg_write  <= 1'b0;
      m_result_src <= res_alu;
      m_mem_write  <= 1'b0;
    end else begin
      m_valid      <= e_valid;
      m_reg_write  <= e_reg_write;
      m_result_src <= e_result_src;
      m_mem_write  <= e_mem_write;
    end
  end

  always_ff @(posedge clk) begin
    m_alu_y <= e_alu_y;
    m_wdata <= e_fwd_b;
    m_imm   <= e_imm;
    m_pc    <= e_pc;
    m_rd    <= e_rd;
  end

  assign dmem_addr  = m_alu_y; // held for loads too
  assign dmem_wdata = m_wdata;
  assign dmem_we    = m_mem_write;

  // M/W
  always_ff @(posedge clk or negedge reset_x) begin
    if (!reset_x) begin
      w_valid      <= 1'b0;
      w_reg_write  <= 1'b0;
      w_result_src <= res_alu;
    end else begin
      w_valid      <= m_valid;
      w_reg_write  <= m_reg_write;
      w_result_src <= m_result_src;
    end
  end

  always_ff @(posedge clk) begin
    w_alu_y <= m_alu_y;
    w_load  <= dmem_rdata;
    w_imm   <= m_imm;
    w_pc    <= m_pc;
    w_rd    <= m_rd;
  end

  always_comb begin
    case (w_result_src)
      res_load: w_result = w_load;
      res_imm:  w_result = w_imm;
      res_pc4:  w_result = w_pc + 32'd4;
      default:  w_result = w_alu_y;
    endcase
  end

  // retire trace, rd and data read zero when nothing is written
  assign retire_valid = w_valid;
  assign retire_pc    = w_pc;
  assign retire_rd    = w_reg_write ? w_rd : '0;
  assign retire_data  = (retire_rd != '0) ? w_result : '0;

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
  input  logic        clk,
  input  logic        reset_x,
  input  logic [31:0] imem_rdata,
  input  logic [31:0] dmem_rdata,
  output logic [31:0] imem_addr,
  output logic [31:0] dmem_addr,
  output logic [31:0] dmem_wdata,
  output logic        dmem_we,
  output logic        retire_valid,
  output logic [31:0] retire_pc,
  output logic [4:0]  retire_rd,
  output logic [31:0] retire_data
);
  import rv_pkg::*;

  instr_t          d_instr;
  logic            reg_write;
  logic [1:0]      result_src;
  logic            mem_write;
  logic [2:0]      alu_ctl;
  logic            alu_src;
  logic            branch;
  logic            branch_ne;
  logic            jump;
  logic [xlen-1:0] imm;

  logic [reg_addr_w-1:0] d_rs1, d_rs2;
  logic [reg_addr_w-1:0] e_rs1, e_rs2, e_rd;
  logic [reg_addr_w-1:0] m_rd, w_rd;
  logic [1:0]            e_result_src, m_result_src, e_pc_src;
  logic                  m_reg_write, w_reg_write;
  logic [1:0]            fwd_a, fwd_b;
  logic                  f_stall, d_stall, d_flush, e_flush;

  rv_decoder dec0 (
    .instr      (d_instr),
    .reg_write  (reg_write),
    .result_src (result_src),
    .mem_write  (mem_write),
    .alu_ctl    (alu_ctl),
    .alu_src    (alu_src),
    .branch     (branch),
    .branch_ne  (branch_ne),
    .jump       (jump),
    .imm        (imm)
  );

  hazard hazard0 (
    .clk          (clk),
    .reset_x      (reset_x),
    .d_rs1        (d_rs1),
    .d_rs2        (d_rs2),
    .e_rs1        (e_rs1),
    .e_rs2        (e_rs2),
    .e_rd         (e_rd),
    .m_rd         (m_rd),
    .w_rd         (w_rd),
    .e_result_src (e_result_src),
    .m_result_src (m_result_src),
    .m_reg_write  (m_reg_write),
    .w_reg_write  (w_reg_write),
    .e_pc_src     (e_pc_src),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b),
    .f_stall      (f_stall),
    .d_stall      (d_stall),
    .d_flush      (d_flush),
    .e_flush      (e_flush)
  );

  rv_datapath dp0 (
    .clk          (clk),
    .reset_x      (reset_x),
    .imem_rdata   (imem_rdata),
    .dmem_rdata   (dmem_rdata),
    .reg_write    (reg_write),
    .result_src   (result_src),
    .mem_write    (mem_write),
    .alu_ctl      (alu_ctl),
    .alu_src      (alu_src),
    .branch       (branch),
    .branch_ne    (branch_ne),
    .jump         (jump),
    .imm          (imm),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b),
    .f_stall      (f_stall),
    .d_stall      (d_stall),
    .d_flush      (d_flush),
    .e_flush      (e_flush),
    .d_instr      (d_instr),
    .d_rs1        (d_rs1),
    .d_rs2        (d_rs2),
    .e_rs1        (e_rs1),
    .e_rs2        (e_rs2),
    .e_rd         (e_rd),
    .m_rd         (m_rd),
    .w_rd         (w_rd),
    .e_result_src (e_result_src),
    .m_result_src (m_result_src),
    .m_reg_write  (m_reg_write),
    .w_reg_write  (w_reg_write),
    .e_pc_src     (e_pc_src),
    .imem_addr    (imem_addr),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_we      (dmem_we),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

endmodule

// ==== bench/rv_iss.svh ====
`ifndef RV_ISS_SVH
`define RV_ISS_SVH

// galois lfsr, one step per random bit
function automatic logic lfsr_step();
  logic b;
  b = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
  return b;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
  return v;
endfunction

// data memory contents before each test
function automatic logic [31:0] fill_word(input logic [7:0] i);
  return {i, ~i, i ^ 8'h3c, 8'ha5};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, op_rtype};
endfunction

function automatic logic [31:0] enc_addi(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [4:0] rd);
  return {imm, rs1, 3'b000, rd, op_itype_alu};
endfunction

function automatic logic [31:0] enc_lw(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [4:0] rd);
  return {imm, rs1, 3'b010, rd, op_load};
endfunction

function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
endfunction

function automatic logic [31:0] enc_br(input logic [12:0] off, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic ne);
  return {off[12], off[10:5], rs2, rs1, {2'b00, ne}, off[4:1], off[11], op_branch};
endfunction

function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, op_lui};
endfunction

function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
endfunction

// one architectural step on the shadow state
function automatic void iss_step(output logic [31:0] pc_o, output logic [4:0] rd_o,
                                 output logic [31:0] data_o);
  rv_pkg::instr_t ins;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] addr;
  logic [31:0] res;
  logic [31:0] nxt;
  logic        wr;
  ins  = imem[iss_pc[9:2]];
  a    = sregs[ins.r_fmt.rs1];
  b    = sregs[ins.r_fmt.rs2];
  nxt  = iss_pc + 32'd4;
  wr   = 1'b0;
  res  = '0;
  addr = a + {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
  case (ins.r_fmt.opcode)
    op_rtype: begin
      wr = 1'b1;
      case (ins.r_fmt.funct3)
        3'b000:  res = ins.r_fmt.funct7[5] ? a - b : a + b;
        3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  res = a ^ b;
        3'b110:  res = a | b;
        3'b111:  res = a & b;
        default: res = a + b;
      endcase
    end
    op_itype_alu: begin
      wr  = 1'b1;
      res = addr; // same sum as rs1 + imm
    end
    op_load: begin
      wr  = 1'b1;
      res = smem[addr[9:2]];
    end
    op_store: begin
      addr = a + {{20{ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
      smem[addr[9:2]] = b;
    end
    op_branch: begin
      if ((a == b) != ins.b_fmt.funct3[0])
        nxt = iss_pc + {{19{ins.b_fmt.imm_12}}, ins.b_fmt.imm_12, ins.b_fmt.imm_11,
                        ins.b_fmt.imm_10_5, ins.b_fmt.imm_4_1, 1'b0};
    end
    op_lui: begin
      wr  = 1'b1;
      res = {ins.u_fmt.imm, 12'h000};
    end
    op_jal: begin
      wr  = 1'b1;
      res = iss_pc + 32'd4;
      nxt = iss_pc + {{11{ins.j_fmt.imm_20}}, ins.j_fmt.imm_20, ins.j_fmt.imm_19_12,
                      ins.j_fmt.imm_11, ins.j_fmt.imm_10_1, 1'b0};
    end
    default: ;
  endcase
  pc_o   = iss_pc;
  rd_o   = wr ? ins.r_fmt.rd : 5'd0;
  data_o = (rd_o != 5'd0) ? res : 32'd0;
  if (rd_o != 5'd0) sregs[rd_o] = res;
  iss_pc = nxt;
endfunction

// random program over x0..x7, branches only jump forward
task automatic gen_random(input int n);
  logic [31:0] r;
  logic [31:0] k;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  int          ow;
  prog.delete();
  for (int i = 0; i < n; i++) begin
    k   = rand_bits(3);
    r   = rand_bits(3);
    rd  = {2'b00, r[2:0]};
    r   = rand_bits(3);
    rs1 = {2'b00, r[2:0]};
    r   = rand_bits(3);
    rs2 = {2'b00, r[2:0]};
    ow  = 1 + int'(rand_bits(2));
    if (i + ow > n) ow = n - i;
    case (k[2:0])
      3'd1: prog.push_back(enc_addi(12'(rand_bits(12)), rs1, rd));
      3'd2: prog.push_back(enc_lui(20'(rand_bits(20)), rd));
      3'd3: prog.push_back(enc_lw({2'b00, 8'(rand_bits(8)), 2'b00}, 5'd0, rd));
      3'd4: prog.push_back(enc_sw({2'b00, 8'(rand_bits(8)), 2'b00}, rs2, 5'd0));
      3'd5: prog.push_back(enc_br(13'(ow * 4), rs2, rs1, lfsr_step()));
      3'd6: prog.push_back(enc_jal(21'(ow * 4), rd));
      default: begin
        r = rand_bits(3);
        case (r[2:0])
          3'd1:    prog.push_back(enc_r(7'h20, rs2, rs1, 3'b000, rd));
          3'd2:    prog.push_back(enc_r(7'h00, rs2, rs1, 3'b111, rd));
          3'd3:    prog.push_back(enc_r(7'h00, rs2, rs1, 3'b110, rd));
          3'd4:    prog.push_back(enc_r(7'h00, rs2, rs1, 3'b100, rd));
          3'd5:    prog.push_back(enc_r(7'h00, rs2, rs1, 3'b010, rd));
          default: prog.push_back(enc_r(7'h00, rs2, rs1, 3'b000, rd));
        endcase
      end
    endcase
  end
  prog.push_back(enc_jal(21'd0, 5'd0)); // end loop
endtask

`endif

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;
  import rv_pkg::*;

  localparam int rand_len      = 200;
  localparam int rand_runs     = 3;
  localparam int planned_instr = 11 + 7 + 15 + 15 + rand_runs * (rand_len + 1);
  localparam int num_tests     = 4 + rand_runs;

  logic        clk;
  logic        reset_x;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_rdata;
  logic [31:0] imem_addr;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_we;
  logic        retire_valid;
  logic [31:0] retire_pc;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] smem [256]; // shadow data memory
  logic [31:0] sregs [32];
  logic [31:0] iss_pc;
  logic [31:0] lfsr_state;
  logic [31:0] prog [$];

  string       cur_test;
  logic        test_active;
  logic        done;
  logic [31:0] end_pc;
  int          retired;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  logic [31:0] exp_pc;
  logic [4:0]  exp_rd;
  logic [31:0] exp_data;

  `include "rv_iss.svh"

  rv_core dut0 (
    .clk          (clk),
    .reset_x      (reset_x),
    .imem_rdata   (imem_rdata),
    .dmem_rdata   (dmem_rdata),
    .imem_addr    (imem_addr),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_we      (dmem_we),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  always #10 clk = ~clk;

  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) dmem[dmem_addr[9:2]] <= dmem_wdata;
  end

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s %s expected %08h actual %08h", cur_test, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_reg(input string what, input logic [4:0] exp, input logic [4:0] act);
    if (exp !== act) begin
      $display("ERROR %s %s expected x%0d actual x%0d", cur_test, what, exp, act);
      test_errors++;
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (test_active && reset_x && retire_valid && !done) begin
      iss_step(exp_pc, exp_rd, exp_data);
      check_word("retire_pc", exp_pc, retire_pc);
      check_reg("retire_rd", exp_rd, retire_rd);
      check_word("retire_data", exp_data, retire_data);
      retired++;
      if (exp_pc == end_pc) done = 1'b1;
    end
  end

  task automatic run_test(input string name);
    @(posedge clk);
    #1;
    reset_x     = 1'b0;
    test_active = 1'b0;
    done        = 1'b0;
    cur_test    = name;
    retired     = 0;
    test_errors = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
      dmem[i] = fill_word(8'(i));
      smem[i] = fill_word(8'(i));
    end
    for (int i = 0; i < 32; i++) sregs[i] = '0;
    iss_pc = '0;
    end_pc = 32'((prog.size() - 1) * 4);
    repeat (2) @(posedge clk);
    #1;
    reset_x     = 1'b1;
    test_active = 1'b1;
    while (!done) @(posedge clk);
    #1;
    test_active = 1'b0;
    for (int i = 0; i < 256; i++) check_word($sformatf("dmem[%0d]", i), smem[i], dmem[i]);
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s passed, %0d retired", name, retired);
    end else begin
      tests_failed++;
      $display("test %s failed, %0d mismatches", name, test_errors);
    end
  endtask

  initial begin
    #(20 * 10 * planned_instr + 20 * 4 * num_tests);
    $display("watchdog timeout, program did not retire");
    $display("Errors found");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    reset_x      = 1'b0;
    test_active  = 1'b0;
    done         = 1'b0;
    tests_passed = 0;
    tests_failed = 0;
    lfsr_state   = 32'h91ba;

    prog = '{enc_addi(12'd5, 5'd0, 5'd1), enc_addi(12'hffd, 5'd0, 5'd2),
             enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd4),
             enc_r(7'h00, 5'd3, 5'd4, 3'b100, 5'd5), enc_r(7'h00, 5'd4, 5'd5, 3'b110, 5'd6),
             enc_r(7'h00, 5'd5, 5'd6, 3'b111, 5'd7), enc_r(7'h00, 5'd6, 5'd7, 3'b010, 5'd8),
             enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd9), enc_r(7'h00, 5'd8, 5'd9, 3'b000, 5'd10),
             enc_jal(21'd0, 5'd0)};
    run_test("alu_chain");

    prog = '{enc_lui(20'h12345, 5'd1), enc_addi(12'h678, 5'd1, 5'd2),
             enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), enc_lui(20'hfffff, 5'd4),
             enc_r(7'h00, 5'd1, 5'd4, 3'b000, 5'd5), enc_addi(12'd1, 5'd4, 5'd6),
             enc_jal(21'd0, 5'd0)};
    run_test("lui_forward");

    prog = '{enc_addi(12'h040, 5'd0, 5'd1), enc_lw(12'h010, 5'd0, 5'd2),
             enc_r(7'h00, 5'd2, 5'd2, 3'b000, 5'd3), enc_lw(12'h014, 5'd0, 5'd4),
             enc_sw(12'h020, 5'd4, 5'd0), enc_sw(12'h024, 5'd3, 5'd0),
             enc_lw(12'h024, 5'd0, 5'd5), enc_addi(12'd1, 5'd5, 5'd6),
             enc_sw(12'h028, 5'd6, 5'd0), enc_lw(12'h028, 5'd0, 5'd7),
             enc_r(7'h20, 5'd5, 5'd7, 3'b000, 5'd8), enc_lw(12'h004, 5'd1, 5'd9),
             enc_sw(12'h008, 5'd9, 5'd1), enc_lw(12'h020, 5'd0, 5'd10),
             enc_jal(21'd0, 5'd0)};
    run_test("load_store");

    prog = '{enc_addi(12'd7, 5'd0, 5'd1), enc_addi(12'd7, 5'd0, 5'd2),
             enc_br(13'd8, 5'd2, 5'd1, 1'b0), enc_addi(12'd1, 5'd0, 5'd3),
             enc_br(13'd8, 5'd2, 5'd1, 1'b1), enc_addi(12'd2, 5'd0, 5'd4),
             enc_br(13'd8, 5'd0, 5'd1, 1'b0), enc_addi(12'd3, 5'd0, 5'd5),
             enc_br(13'd12, 5'd0, 5'd1, 1'b1), enc_addi(12'd4, 5'd0, 5'd6),
             enc_addi(12'd5, 5'd0, 5'd7), enc_jal(21'd8, 5'd8),
             enc_addi(12'd6, 5'd0, 5'd9), enc_r(7'h00, 5'd1, 5'd8, 3'b000, 5'd10),
             enc_jal(21'd0, 5'd0)};
    run_test("branch_jal");

    for (int t = 0; t < rand_runs; t++) begin
      gen_random(rand_len);
      run_test($sformatf("random_%0d", t));
    end

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== rv_core.f ====
+incdir+bench
rtl/rv_pkg.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_decoder.sv
rtl/hazard.sv
rtl/rv_datapath.sv
rtl/rv_core.sv
bench/rv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module rv_core_tb -f rv_core.f -o rv_core_sim
./obj_dir/rv_core_sim > sim.log
cat sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
exit 0
